// ==== verilog/mipsPkg.sv ====
// shared widths, instruction encodings, ALU operations and decoded control for the MIPS core
package mipsPkg;

  // ====================
  // widths
  // ====================

  // data and instruction words
  typedef logic [31:0] word_t;
  // register file index
  typedef logic [4:0]  regAddr_t;
  // data memory word address, 128 words
  typedef logic [6:0]  dmemAddr_t;
  // instruction byte address
  typedef logic [31:0] pc_t;

  // ====================
  // encodings
  // ====================

  // primary opcodes, instr[31:26]
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_JAL   = 6'h03;

  // R-type funct field, instr[5:0]
  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR  = 6'h25;
  localparam logic [5:0] FN_SLT = 6'h2a;
  localparam logic [5:0] FN_JR  = 6'h08;

  // jal destination, return address register
  localparam regAddr_t REG_LINK = 5'd31;

  // ====================
  // control
  // ====================

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } aluOp_e;

  // one instruction worth of decoded control
  typedef struct packed {
    logic        regWrite;
    // write rd instead of rt
    logic        regDst;
    logic        aluSrcImm;
    logic        memRead;
    logic        memWrite;
    logic        memToReg;
    logic        branch;
    logic        jump;
    logic        jumpReg;
    // write PC+4 to register 31
    logic        link;
    aluOp_e      aluOp;
    // sign-extended 16-bit immediate
    word_t       imm;
    logic [25:0] jumpTarget;
  } ctrl_t;

endpackage

// ==== verilog/mipsAlu.sv ====
// integer ALU for the core: add, sub, and, or, signed set-less-than and a zero flag
`timescale 1ns/1ps

module mipsAlu (
  input  mipsPkg::word_t  a,
  input  mipsPkg::word_t  b,
  input  mipsPkg::aluOp_e op,
  output mipsPkg::word_t  result,
  output logic            zero
);

  // ====================
  // operations
  // ====================

  always_comb begin
    case (op)
      mipsPkg::ALU_ADD: result = a + b;
      // also the beq compare
      mipsPkg::ALU_SUB: result = a - b;
      mipsPkg::ALU_AND: result = a & b;
      mipsPkg::ALU_OR: result = a | b;
      // two's complement compare, so -1 < 1
      mipsPkg::ALU_SLT: begin
        if ($signed(a) < $signed(b)) begin
          result = 32'd1;
        end else begin
          result = 32'd0;
        end
      end
      default: result = a + b;
    endcase
  end

  // ====================
  // flag
  // ====================

  // any operation, only beq looks at it
  assign zero = (result == '0);

endmodule

// ==== verilog/mipsRegFile.sv ====
// general purpose register file, two combinational reads and one clocked write per cycle
`timescale 1ns/1ps

module mipsRegFile (
  input  logic             clk,
  input  logic             we,
  input  mipsPkg::regAddr_t rsAddr,
  input  mipsPkg::regAddr_t rtAddr,
  input  mipsPkg::regAddr_t wAddr,
  input  mipsPkg::word_t    wData,
  output mipsPkg::word_t    rsData,
  output mipsPkg::word_t    rtData
);

  // ====================
  // storage
  // ====================

  // register 0 has no storage
  mipsPkg::word_t regs [1:31];

  // writes land at the same edge as the pc update
  always_ff @(posedge clk) begin
    if (we && (wAddr != '0)) begin
      regs[wAddr] <= wData;
    end
  end

  // ====================
  // read ports
  // ====================

  // index 0 always reads zero
  always_comb begin
    if (rsAddr == '0) begin
      rsData = '0;
    end else begin
      rsData = regs[rsAddr];
    end
  end

  always_comb begin
    if (rtAddr == '0) begin
      rtData = '0;
    end else begin
      rtData = regs[rtAddr];
    end
  end

endmodule

// ==== verilog/mipsDecoder.sv ====
// combinational decode of one instruction word into the core control struct
`timescale 1ns/1ps

module mipsDecoder (
  input  mipsPkg::word_t instr,
  output mipsPkg::ctrl_t ctrl
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  always_comb begin
    // start from a no-op, unknown encodings stay this way
    ctrl = '0;
    ctrl.aluOp = mipsPkg::ALU_ADD;

    // instruction fields, harmless when unused
    ctrl.imm        = {{16{instr[15]}}, instr[15:0]};
    ctrl.jumpTarget = instr[25:0];

    case (opcode)
      // ====================
      // R-type
      // ====================
      mipsPkg::OP_RTYPE: begin
        case (funct)
          mipsPkg::FN_ADD: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = mipsPkg::ALU_ADD;
          end
          mipsPkg::FN_SUB: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = mipsPkg::ALU_SUB;
          end
          mipsPkg::FN_AND: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = mipsPkg::ALU_AND;
          end
          mipsPkg::FN_OR: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = mipsPkg::ALU_OR;
          end
          mipsPkg::FN_SLT: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = mipsPkg::ALU_SLT;
          end
          // return through rs, no write
          mipsPkg::FN_JR: ctrl.jumpReg = 1'b1;
          default: ;
        endcase
      end

      // ====================
      // I/J-type
      // ====================
      // address = rs + offset
      mipsPkg::OP_LW: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.memToReg  = 1'b1;
      end
      mipsPkg::OP_SW: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      // rs - rt feeds the zero flag
      mipsPkg::OP_BEQ: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = mipsPkg::ALU_SUB;
      end
      mipsPkg::OP_J: ctrl.jump = 1'b1;
      // no delay slot, link is PC+4
      mipsPkg::OP_JAL: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ;
    endcase

    // a store never retires a register write in the same cycle
    noStoreAndWrite: assert (!(ctrl.memWrite && ctrl.regWrite))
      else $error("store and register write decoded together: %h", instr);
  end

endmodule

// ==== verilog/mipsFetch.sv ====
// program counter and next-PC selection, one instruction address per clock for the core
`timescale 1ns/1ps

module mipsFetch (
  input  logic          clk,
  input  logic          rst,
  input  mipsPkg::ctrl_t ctrl,
  input  logic          aluZero,
  input  mipsPkg::word_t rsData,
  output mipsPkg::pc_t   pc,
  output mipsPkg::pc_t   pcPlus4
);

  mipsPkg::pc_t nextPc;
  mipsPkg::pc_t branchTarget;
  mipsPkg::pc_t jumpTarget;

  // ====================
  // candidate targets
  // ====================

  // sequential address
  assign pcPlus4 = pc + 32'd4;

  // word offset relative to the following instruction
  assign branchTarget = pcPlus4 + {ctrl.imm[29:0], 2'b00};

  // pseudo-direct, keeps the upper 4 bits of the current region
  assign jumpTarget = {pcPlus4[31:28], ctrl.jumpTarget, 2'b00};

  // priority: jr, then j/jal, then taken beq
  always_comb begin
    if (ctrl.jumpReg) begin
      nextPc = rsData;
    end else if (ctrl.jump) begin
      nextPc = jumpTarget;
    end else if (ctrl.branch && aluZero) begin
      // beq compares by subtract, zero means equal
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // ====================
  // pc register
  // ====================

  // first fetch after reset is address 0
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

  // a jr to a misaligned register value would break this
  pcAligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

// ==== verilog/mipsCore.sv ====
// single-cycle MIPS-32 subset core top, with instruction port, SRAM data port and writeback trace
`timescale 1ns/1ps

module mipsCore (
  input  logic               clk,
  input  logic               rst,
  output mipsPkg::pc_t       imemAddr,
  input  mipsPkg::word_t     imemData,
  output logic               dmemCen,
  output logic               dmemWen,
  output logic               dmemOen,
  output mipsPkg::dmemAddr_t dmemAddr,
  output mipsPkg::word_t     dmemWdata,
  input  mipsPkg::word_t     dmemRdata,
  output logic               wbValid,
  output mipsPkg::regAddr_t  wbAddr,
  output mipsPkg::word_t     wbData
);

  mipsPkg::ctrl_t    ctrl;
  mipsPkg::pc_t      pc;
  mipsPkg::pc_t      pcPlus4;
  mipsPkg::regAddr_t rsAddr;
  mipsPkg::regAddr_t rtAddr;
  mipsPkg::regAddr_t rdAddr;
  mipsPkg::word_t    rsData;
  mipsPkg::word_t    rtData;
  mipsPkg::word_t    aluB;
  mipsPkg::word_t    aluResult;
  logic              aluZero;

  // ====================
  // fetch and decode
  // ====================

  mipsFetch i_mipsFetch (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .aluZero (aluZero),
    .rsData  (rsData),
    .pc      (pc),
    .pcPlus4 (pcPlus4)
  );

  // instruction answers combinationally within the cycle
  assign imemAddr = pc;

  mipsDecoder i_mipsDecoder (
    .instr (imemData),
    .ctrl  (ctrl)
  );

  // register fields
  assign rsAddr = imemData[25:21];
  assign rtAddr = imemData[20:16];
  assign rdAddr = imemData[15:11];

  // ====================
  // register file and ALU
  // ====================

  mipsRegFile i_mipsRegFile (
    .clk    (clk),
    .we     (wbValid),
    .rsAddr (rsAddr),
    .rtAddr (rtAddr),
    .wAddr  (wbAddr),
    .wData  (wbData),
    .rsData (rsData),
    .rtData (rtData)
  );

  // offset for lw/sw, rt otherwise
  assign aluB = ctrl.aluSrcImm ? ctrl.imm : rtData;

  mipsAlu i_mipsAlu (
    .a      (rsData),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // ====================
  // data port
  // ====================

  // enables held inactive while in reset
  assign dmemCen   = !(rst && (ctrl.memRead || ctrl.memWrite));
  assign dmemWen   = !(rst && ctrl.memWrite);
  assign dmemOen   = !(rst && ctrl.memRead);
  // byte address to word address
  assign dmemAddr  = aluResult[8:2];
  assign dmemWdata = rtData;

  // ====================
  // writeback
  // ====================

  // jal -> 31, R-type -> rd, lw -> rt
  assign wbAddr = ctrl.link ? mipsPkg::REG_LINK : (ctrl.regDst ? rdAddr : rtAddr);

  assign wbData = ctrl.link ? pcPlus4 : (ctrl.memToReg ? dmemRdata : aluResult);

  // writes to register 0 are not reported
  assign wbValid = rst && ctrl.regWrite && (wbAddr != '0);

  // a write strobe without chip select would be lost by the SRAM
  wenNeedsCen: assert property (@(posedge clk) disable iff (!rst) !dmemWen |-> !dmemCen)
    else $error("dmemWen low while dmemCen high");

endmodule

// ==== tb/tbClock.sv ====
// clock source for the core testbench, 20 ns period, starts low
`timescale 1ns/1ps

module tbClock (
  output logic clk
);

  // ====================
  // free-running clock
  // ====================

  initial begin
    clk = 1'b0;
    // half of the 20 ns period
    forever begin
      #10 clk = ~clk;
    end
  end

endmodule

// ==== tb/mipsCoreTb.sv ====
// MIPS core testbench that runs the program and expected events of the testdata file
`timescale 1ns/1ps

module mipsCoreTb;

  localparam int RESET_CYCLES = 16;
  // quiet cycles after the last event catch extra writes
  localparam int DRAIN_CYCLES = 4;
  localparam string DATA_FILE = "tb/mipsTestdata.txt";
  // memory instructions shown at address 0 during reset
  // sw $0,0($0)
  localparam mipsPkg::word_t RESET_STORE = 32'hac000000;
  // lw $1,0($0)
  localparam mipsPkg::word_t RESET_LOAD  = 32'h8c010000;

  // one expected register write or store
  typedef struct packed {
    logic           store;
    logic [6:0]     addr;
    mipsPkg::word_t data;
    logic [7:0]     group;
  } expEvent_t;

  logic               clk;
  logic               rst;
  mipsPkg::pc_t       imemAddr;
  mipsPkg::word_t     imemData;
  logic               dmemCen;
  logic               dmemWen;
  logic               dmemOen;
  mipsPkg::dmemAddr_t dmemAddr;
  mipsPkg::word_t     dmemWdata;
  mipsPkg::word_t     dmemRdata;
  logic               wbValid;
  mipsPkg::regAddr_t  wbAddr;
  mipsPkg::word_t     wbData;

  mipsPkg::word_t imem [0:255];
  mipsPkg::word_t dmem [0:127];
  mipsPkg::word_t progWords[$];
  expEvent_t      events[$];
  string          groupNames[$];

  int evIndex;
  int checks;
  int errors;
  int curGroup;
  int groupChecks;
  int groupErrors;

  tbClock i_tbClock (
    .clk (clk)
  );

  mipsCore i_mipsCore (
    .clk       (clk),
    .rst       (rst),
    .imemAddr  (imemAddr),
    .imemData  (imemData),
    .dmemCen   (dmemCen),
    .dmemWen   (dmemWen),
    .dmemOen   (dmemOen),
    .dmemAddr  (dmemAddr),
    .dmemWdata (dmemWdata),
    .dmemRdata (dmemRdata),
    .wbValid   (wbValid),
    .wbAddr    (wbAddr),
    .wbData    (wbData)
  );

  // ====================
  // memory models
  // ====================

  // instruction word answers in the same cycle
  assign imemData = imem[imemAddr[9:2]];

  // SRAM read data only while selected and output enabled
  assign dmemRdata = (!dmemCen && !dmemOen) ? dmem[dmemAddr] : '0;

  // cleared while the core is in reset
  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 128; i++) begin
        dmem[i] <= '0;
      end
    end else if (!dmemCen && !dmemWen) begin
      dmem[dmemAddr] <= dmemWdata;
    end
  end

  // ====================
  // testdata reading
  // ====================

  function automatic string trimLine(input string s);
    int n;
    n = s.len();
    while (n > 0 && (s.getc(n - 1) == "\n" || s.getc(n - 1) == "\r" || s.getc(n - 1) == " ")) begin
      n--;
    end
    return s.substr(0, n - 1);
  endfunction

  // P word, G group, W reg value, S word address data
  task automatic parseLine(input string line);
    int             num;
    mipsPkg::word_t value;
    expEvent_t      ev;
    if (line.len() == 0 || line.getc(0) == "#") begin
      return;
    end
    ev = '0;
    // events belong to the last group named
    ev.group = 8'(groupNames.size() - 1);
    case (line.getc(0))
      "P": begin
        void'($sscanf(line, "P %h", value));
        progWords.push_back(value);
      end
      "G": groupNames.push_back(line.substr(2, line.len() - 1));
      "W", "S": begin
        void'($sscanf(line.substr(2, line.len() - 1), "%d %h", num, value));
        ev.store = (line.getc(0) == "S");
        ev.addr  = 7'(num);
        ev.data  = value;
        events.push_back(ev);
      end
      default: begin
        $display("testdata line not understood: %s", line);
        errors++;
      end
    endcase
  endtask

  task automatic loadTestdata(output bit ok);
    int    fd;
    int    n;
    string line;
    ok = 1'b0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("could not open the testdata file %s", DATA_FILE);
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) begin
        parseLine(trimLine(line));
      end
    end
    $fclose(fd);
    ok = (progWords.size() > 0) && (events.size() > 0);
    if (!ok) begin
      $display("testdata file holds no program or no expected events");
    end
  endtask

  // ====================
  // checking and reporting
  // ====================

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic closeGroup();
    if (errors == groupErrors) begin
      $display("group %s passed, %0d checks", groupNames[curGroup], checks - groupChecks);
    end else begin
      $display("group %s failed, %0d errors", groupNames[curGroup], errors - groupErrors);
    end
    groupChecks = checks;
    groupErrors = errors;
  endtask

  task automatic enterGroup(input int g);
    if (g != curGroup) begin
      closeGroup();
      curGroup = g;
    end
  endtask

  // pre-edge values that the edge commits
  task automatic sampleEvents();
    expEvent_t ev;
    logic      isStore;
    isStore = !dmemCen && !dmemWen;
    if (!wbValid && !isStore) begin
      return;
    end
    if (evIndex >= events.size()) begin
      errors++;
      if (isStore) begin
        $display("unexpected store of %h to word %0d after the last expected event",
                 dmemWdata, dmemAddr);
      end else begin
        $display("unexpected write of %h to register %0d after the last expected event",
                 wbData, wbAddr);
      end
      return;
    end
    ev = events[evIndex];
    evIndex++;
    enterGroup(int'(ev.group));
    if (ev.store != isStore) begin
      errors++;
      if (ev.store) begin
        $display("expected a store at %0t ns but register %0d was written", $time, wbAddr);
      end else begin
        $display("expected a register write at %0t ns but word %0d was stored", $time, dmemAddr);
      end
    end else if (isStore) begin
      checkValue("store word address", 32'(dmemAddr), 32'(ev.addr));
      checkValue("store data", dmemWdata, ev.data);
    end else begin
      checkValue("written register", 32'(wbAddr), 32'(ev.addr));
      checkValue("written data", wbData, ev.data);
    end
  endtask

  task automatic runProgram();
    int cycles;
    int limit;
    int drain;
    limit  = 10 * progWords.size() + RESET_CYCLES;
    cycles = 0;
    drain  = 0;
    // pc settles at the first edge of reset
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      cycles++;
      if (i > 0) begin
        checkValue("imemAddr in reset", imemAddr, 32'd0);
        checkValue("dmemCen in reset", 32'(dmemCen), 32'd1);
        checkValue("dmemWen in reset", 32'(dmemWen), 32'd1);
        checkValue("dmemOen in reset", 32'(dmemOen), 32'd1);
        checkValue("wbValid in reset", 32'(wbValid), 32'd0);
      end
      #1;
      // store and load take turns, reset must keep both gated off
      if (i < RESET_CYCLES - 1) begin
        imem[0] = (i % 2 == 0) ? RESET_STORE : RESET_LOAD;
      end
    end
    // program word 0 comes back with the reset release
    imem[0] = progWords[0];
    rst = 1'b1;
    @(posedge clk);
    cycles++;
    checkValue("first fetch address", imemAddr, 32'd0);
    sampleEvents();
    // program parks in a jump-to-self once done
    while (evIndex < events.size() || drain < DRAIN_CYCLES) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        $display("timeout after %0d cycles, %0d expected events never appeared",
                 cycles, events.size() - evIndex);
        errors++;
        break;
      end
      sampleEvents();
      if (evIndex >= events.size()) begin
        drain++;
      end
    end
  endtask

  task automatic finishRun();
    closeGroup();
    $display("%0d checks, %0d errors, %0d of %0d events seen",
             checks, errors, evIndex, events.size());
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    bit loaded;
    rst         = 1'b0;
    evIndex     = 0;
    checks      = 0;
    errors      = 0;
    curGroup    = 0;
    groupChecks = 0;
    groupErrors = 0;
    groupNames.push_back("reset");
    // unused slots hold an illegal opcode tagged with their index
    for (int i = 0; i < 256; i++) begin
      imem[i] = {6'h3f, 26'(i)};
    end
    loadTestdata(loaded);
    if (loaded) begin
      for (int i = 0; i < progWords.size(); i++) begin
        imem[i] = progWords[i];
      end
      runProgram();
    end else begin
      errors++;
    end
    finishRun();
  end

endmodule

// ==== tb/mipsTestdata.txt ====
# P <hex instruction word> [asm], then G <group name>, W <register> <hex value>, S <word addr> <hex data>
# W and S lines list register writes and stores in the order the core must produce them
P 0C000002  0x00 jal 0x08
P 03FF4820  0x04 add $9,$31,$31   skipped
P 03E00820  0x08 add $1,$31,$0
P 00211020  0x0c add $2,$1,$1
P 00421820  0x10 add $3,$2,$2
P 00222022  0x14 sub $4,$1,$2
P 00412825  0x18 or  $5,$2,$1
P 00A23024  0x1c and $6,$5,$2
P 0081382A  0x20 slt $7,$4,$1
P 0024402A  0x24 slt $8,$1,$4
P 00835020  0x28 add $10,$4,$3
P AC450008  0x2c sw  $5,8($2)
P 8C4B0008  0x30 lw  $11,8($2)
P AC640004  0x34 sw  $4,4($3)
P 8C0C0014  0x38 lw  $12,20($0)
P 10220001  0x3c beq $1,$2,+1     not taken
P 00226820  0x40 add $13,$1,$2
P 10AA0002  0x44 beq $5,$10,+2    taken
P 00217020  0x48 add $14,$1,$1    skipped
P 00217820  0x4c add $15,$1,$1    skipped
P 00428020  0x50 add $16,$2,$2
P 08000017  0x54 j   0x5c
P 00218820  0x58 add $17,$1,$1    skipped
P 00239020  0x5c add $18,$1,$3
P 0C00001B  0x60 jal 0x6c
P 00439820  0x64 add $19,$2,$3
P 0800001D  0x68 j   0x74
P 0063A020  0x6c add $20,$3,$3
P 03E00008  0x70 jr  $31
P 00210020  0x74 add $0,$1,$1
P 0001A820  0x78 add $21,$0,$1
P FC22B020  0x7c illegal opcode
P 0021B821  0x80 illegal funct
P 0061B025  0x84 or  $22,$3,$1
P 08000022  0x88 j   0x88
G setup
W 31 00000004
W 1 00000004
W 2 00000008
W 3 00000010
G arith
W 4 fffffffc
W 5 0000000c
W 6 00000008
W 7 00000001
W 8 00000000
W 10 0000000c
G memory
S 4 0000000c
W 11 0000000c
S 5 fffffffc
W 12 fffffffc
G branch
W 13 0000000c
W 16 00000010
G jump
W 18 00000014
W 31 00000064
W 20 00000020
W 19 00000018
G zeroAndNoop
W 21 00000004
W 22 00000014

// ==== src.f ====
verilog/mipsPkg.sv
verilog/mipsAlu.sv
verilog/mipsRegFile.sv
verilog/mipsDecoder.sv
verilog/mipsFetch.sv
verilog/mipsCore.sv
tb/tbClock.sv
tb/mipsCoreTb.sv

// ==== Makefile ====
# Verilator build and run of the MIPS core testbench

SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := mipsCoreTb
FILELIST := src.f
BUILDDIR := obj_dir
LOG      := sim.log
PASSMSG  := TEST OK
FAILMSG  := TEST FAILED

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	-./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILDDIR) $(LOG)
